// File: vlog.f
verilog/bus_pkg.sv
verilog/analog_pkg.sv
verilog/sys_bus_decoder.sv
verilog/adc_frontend.sv
verilog/dac_channel.sv
verilog/dac_output.sv
verilog/pitaya_top.sv
verification/tb_checker.sv
verification/tb_pitaya_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and decide pass or fail
# from the line the testbench prints at the end.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
  -f vlog.f \
  --top-module tb_pitaya_top \
  -o sim_tb

output=$(./obj_dir/sim_tb)
echo "$output"

if echo "$output" | grep -qx "TEST OK"; then
  exit 0
else
  exit 1
fi

// File: verification/tb_pitaya_top.sv
/*
 * Testbench top. Clock and reset, a table of gain, offset and ADC
 * rows applied in a loop, and a bus master task for register access.
 */
`timescale 1ns/1ps

module tb_pitaya_top;

  import bus_pkg::*;
  import analog_pkg::*;

  localparam int N_CH     = 2;
  localparam int N_SAMPLE = 20;  // ADC samples per row
  localparam int RANDOM   = -1;  // code column, draw a fresh code
  localparam int ACK_WAIT = 4;   // master gives up after this many cycles

  logic            adc_clk;
  logic            reset_i;
  dac_code_t       adc_dat_a_i;
  dac_code_t       adc_dat_b_i;
  sys_addr_t       sys_addr_i;
  sys_data_t       sys_wdata_i;
  logic            sys_wen_i;
  logic            sys_ren_i;
  sys_data_t       sys_rdata_o;
  logic            sys_ack_o;
  dac_code_t       dac_dat_a_o;
  dac_code_t       dac_dat_b_o;
  logic            dac_rst_o;
  logic [N_CH-1:0] led_o;

  // stimulus table, one entry per row
  string row_name   [$];
  int    row_gain_a [$];
  int    row_off_a  [$];
  int    row_gain_b [$];
  int    row_off_b  [$];
  int    row_code_a [$];
  int    row_code_b [$];

  int seed        = 32'h2252;
  int cycles      = 0;
  int cycle_limit = 200;  // set once the table is built
  int data_errs;
  int bus_errs;

  initial begin
    adc_clk = 1'b0;
    forever #5 adc_clk = ~adc_clk;  // 100 MHz
  end

  pitaya_top #(.N_CH(N_CH)) i_dut (
    .adc_clk     (adc_clk),
    .reset_i     (reset_i),
    .adc_dat_a_i (adc_dat_a_i),
    .adc_dat_b_i (adc_dat_b_i),
    .sys_addr_i  (sys_addr_i),
    .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .sys_rdata_o (sys_rdata_o),
    .sys_ack_o   (sys_ack_o),
    .dac_dat_a_o (dac_dat_a_o),
    .dac_dat_b_o (dac_dat_b_o),
    .dac_rst_o   (dac_rst_o),
    .led_o       (led_o)
  );

  tb_checker #(.N_CH(N_CH)) i_checker (
    .adc_clk (adc_clk),      .reset_i   (reset_i),
    .adc_a_i (adc_dat_a_i),  .adc_b_i   (adc_dat_b_i),
    .addr_i  (sys_addr_i),   .wdata_i   (sys_wdata_i),
    .wen_i   (sys_wen_i),    .ren_i     (sys_ren_i),
    .rdata_i (sys_rdata_o),  .ack_i     (sys_ack_o),
    .dac_a_i (dac_dat_a_o),  .dac_b_i   (dac_dat_b_o),
    .dac_rst_i (dac_rst_o),  .led_i     (led_o),
    .data_err_o (data_errs), .bus_err_o (bus_errs)
  );

  task automatic add_row(input string name, input int gain_a, input int off_a,
                         input int gain_b, input int off_b, input int code_a, input int code_b);
    row_name.push_back(name);
    row_gain_a.push_back(gain_a);
    row_off_a.push_back(off_a);
    row_gain_b.push_back(gain_b);
    row_off_b.push_back(off_b);
    row_code_a.push_back(code_a);
    row_code_b.push_back(code_b);
  endtask

  function automatic sys_addr_t reg_addr(input int region, input int slot);
    return (sys_addr_t'(region) << REGION_LSB) | (sys_addr_t'(slot) << REG_LSB);
  endfunction

  // ----------------------------------------
  // bus master, one access outstanding, address held until ack
  task automatic bus_access(input logic wr, input sys_addr_t addr, input sys_data_t data);
    int waited;
    waited = 0;
    @(posedge adc_clk);
    sys_addr_i  <= addr;
    sys_wdata_i <= data;
    sys_wen_i   <= wr;
    sys_ren_i   <= ~wr;
    @(negedge adc_clk);
    while (!sys_ack_o && waited < ACK_WAIT) begin
      @(posedge adc_clk);
      sys_wen_i <= 1'b0;  // strobe lasts one cycle
      sys_ren_i <= 1'b0;
      @(negedge adc_clk);
      waited++;
    end
    @(posedge adc_clk);
    sys_wen_i <= 1'b0;
    sys_ren_i <= 1'b0;
  endtask

  task automatic run_row(input int r);
    int rnd;
    i_checker.set_test(row_name[r]);
    bus_access(1'b1, reg_addr(CH_BASE_REGION, 1), row_gain_a[r]);
    bus_access(1'b1, reg_addr(CH_BASE_REGION, 0), row_off_a[r]);
    bus_access(1'b1, reg_addr(CH_BASE_REGION + 1, 1), row_gain_b[r]);
    bus_access(1'b1, reg_addr(CH_BASE_REGION + 1, 0), row_off_b[r]);
    for (int n = 0; n < N_SAMPLE; n++) begin
      @(posedge adc_clk);
      rnd = $random(seed);
      adc_dat_a_i <= (row_code_a[r] == RANDOM) ? rnd[13:0] : dac_code_t'(row_code_a[r]);
      rnd = $random(seed);
      adc_dat_b_i <= (row_code_b[r] == RANDOM) ? rnd[13:0] : dac_code_t'(row_code_b[r]);
    end
    repeat (5) @(posedge adc_clk);  // drain the pipeline
  endtask

  task automatic print_counts();
    $display("errors: data path %0d, bus %0d", data_errs, bus_errs);
  endtask

  // ----------------------------------------
  // run limit
  always @(posedge adc_clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: run still going after %0d cycles", cycle_limit);
      print_counts();
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin
    adc_dat_a_i <= '0;
    adc_dat_b_i <= '0;
    sys_addr_i  <= '0;
    sys_wdata_i <= '0;
    sys_wen_i   <= 1'b0;
    sys_ren_i   <= 1'b0;
    reset_i     <= 1'b1;

    //       name          gain_a off_a  gain_b off_b  code_a   code_b
    add_row("unity",       256,   0,     256,   0,     RANDOM,  RANDOM);
    add_row("gain_offset", 384,   100,   -128,  -250,  RANDOM,  RANDOM);
    add_row("neg_gain",    -512,  -1000, 64,    3000,  RANDOM,  RANDOM);
    add_row("sat_high",    1024,  0,     256,   0,     'h0000,  'h0000);   // +8191 in
    add_row("sat_low",     256,   0,     1024,  0,     'h3FFF,  'h3FFF);   // -8192 in
    add_row("sat_offset",  256,   8191,  256,   -8192, RANDOM,  RANDOM);
    cycle_limit = row_name.size() * 40 + 200;

    repeat (5) @(posedge adc_clk);
    reset_i <= 1'b0;

    i_checker.set_test("reg_access");
    bus_access(1'b1, reg_addr(1, 1), -300);        // negative gain, ch 0
    bus_access(1'b1, reg_addr(1, 0), -1234);
    bus_access(1'b1, reg_addr(1, 2), 32'h1234);    // unused slot
    bus_access(1'b1, reg_addr(2, 1), 32'h7FFF);    // largest gain, ch 1
    bus_access(1'b1, reg_addr(2, 0), 8191);
    for (int s = 0; s < 4; s++) begin
      bus_access(1'b0, reg_addr(1, s), 0);
      bus_access(1'b0, reg_addr(2, s), 0);
    end

    i_checker.set_test("empty_region");
    bus_access(1'b0, reg_addr(0, 1), 0);
    for (int rg = CH_BASE_REGION + N_CH; rg < N_REGIONS; rg++) begin
      bus_access(1'b0, reg_addr(rg, 0), 0);
    end

    for (int r = 0; r < row_name.size(); r++) begin
      run_row(r);
    end

    repeat (2) @(posedge adc_clk);
    print_counts();
    if (data_errs + bus_errs == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: verification/tb_checker.sv
/*
 * Testbench checker. Follows the DUT ports with a cycle model of the
 * sample path and the register map, and counts mismatches.
 */
`timescale 1ns/1ps

module tb_checker #(
  parameter int N_CH = 2
) (
  input  logic                  adc_clk,
  input  logic                  reset_i,
  input  analog_pkg::dac_code_t adc_a_i,    // DUT inputs, as driven
  input  analog_pkg::dac_code_t adc_b_i,
  input  bus_pkg::sys_addr_t    addr_i,
  input  bus_pkg::sys_data_t    wdata_i,
  input  logic                  wen_i,
  input  logic                  ren_i,
  input  bus_pkg::sys_data_t    rdata_i,    // DUT outputs
  input  logic                  ack_i,
  input  analog_pkg::dac_code_t dac_a_i,
  input  analog_pkg::dac_code_t dac_b_i,
  input  logic                  dac_rst_i,
  input  logic [N_CH-1:0]       led_i,
  output int                    data_err_o,
  output int                    bus_err_o
);

  import bus_pkg::*;
  import analog_pkg::*;

  string           test_name = "reset";  // tag for error lines
  int              s1_m   [2];           // signed samples after the front end
  int              prod_m [N_CH];        // stage 2
  int              res_m  [N_CH];        // stage 3
  int              gain_m [N_CH];
  int              off_m  [N_CH];
  logic [N_CH-1:0] sat_m;
  logic [N_CH-1:0] led_m;
  dac_code_t       out_a_m;              // stage 4
  dac_code_t       out_b_m;
  logic            started   = 1'b0;     // first edge seen
  logic            ack_due   = 1'b0;     // channel ack expected now
  logic            rd_due    = 1'b0;
  sys_data_t       rd_exp    = '0;
  int              data_errs = 0;
  int              bus_errs  = 0;

  assign data_err_o = data_errs;
  assign bus_err_o  = bus_errs;

  task automatic set_test(input string name);
    test_name = name;
  endtask

  task automatic report_value(input string what, input sys_data_t expected,
                              input sys_data_t actual);
    $display("FAILED %s: %s expected %0h, actual %0h", test_name, what, expected, actual);
  endtask

  // negative slope code, msb kept and the low bits inverted
  function automatic int code_to_int(input dac_code_t code);
    int v;
    v = int'(code ^ 14'h1FFF);
    if (v > SAT_MAX) v = v - (1 << SAMPLE_W);  // upper half is negative
    return v;
  endfunction

  function automatic dac_code_t int_to_code(input int v);
    dac_code_t t;
    t = v[SAMPLE_W-1:0];
    return t ^ 14'h1FFF;
  endfunction

  // register map as the model holds it, slots 2 and 3 read zero
  function automatic sys_data_t read_value(input int region, input int slot);
    sys_data_t v;
    v = '0;
    for (int c = 0; c < N_CH; c++) begin
      if (region == CH_BASE_REGION + c) begin
        if (slot == int'(REG_OFFSET)) v = sys_data_t'(off_m[c]);  // sign extended
        if (slot == int'(REG_GAIN)) v = sys_data_t'(gain_m[c]);
      end
    end
    return v;
  endfunction

  // ----------------------------------------
  // model, one step per rising edge
  always @(posedge adc_clk) begin : model_step
    int sum;
    int region;
    int slot;
    region  = int'(addr_i[REGION_LSB +: REGION_W]);
    slot    = int'(addr_i[REG_LSB +: REG_W]);
    started <= 1'b1;
    if (reset_i) begin
      s1_m[0] <= 0;
      s1_m[1] <= 0;
      for (int c = 0; c < N_CH; c++) begin
        prod_m[c] <= 0;
        res_m[c]  <= 0;
        gain_m[c] <= 0;
        off_m[c]  <= 0;
      end
      sat_m   <= '0;
      led_m   <= '0;
      out_a_m <= 14'h1FFF;  // zero sample in DAC code
      out_b_m <= 14'h1FFF;
    end else begin
      s1_m[0] <= code_to_int(adc_a_i);
      s1_m[1] <= code_to_int(adc_b_i);
      for (int c = 0; c < N_CH; c++) begin
        prod_m[c] <= s1_m[c % 2] * gain_m[c];          // gain at this edge
        sum = (prod_m[c] >>> KP_FRAC) + off_m[c];      // offset at this edge
        if (sum > SAT_MAX) begin
          res_m[c] <= SAT_MAX;
          sat_m[c] <= 1'b1;
        end else if (sum < SAT_MIN) begin
          res_m[c] <= SAT_MIN;
          sat_m[c] <= 1'b1;
        end else begin
          res_m[c] <= sum;
          sat_m[c] <= 1'b0;
        end
        if (wen_i && region == CH_BASE_REGION + c) begin
          if (slot == int'(REG_OFFSET)) off_m[c] <= int'($signed(wdata_i[SAMPLE_W-1:0]));
          if (slot == int'(REG_GAIN)) gain_m[c] <= int'($signed(wdata_i[GAIN_W-1:0]));
        end
      end
      out_a_m <= int_to_code(res_m[0]);
      out_b_m <= int_to_code(res_m[N_CH-1]);
      led_m   <= sat_m;
    end
  end

  // ----------------------------------------
  // compare on the falling edge, all ports settled
  always @(negedge adc_clk) begin : compare
    int   region;
    logic in_ch;
    if (started) begin
      if (dac_a_i !== out_a_m) begin
        report_value("dac_dat_a_o", 32'(out_a_m), 32'(dac_a_i));
        data_errs++;
      end
      if (dac_b_i !== out_b_m) begin
        report_value("dac_dat_b_o", 32'(out_b_m), 32'(dac_b_i));
        data_errs++;
      end
      if (led_i !== led_m) begin
        report_value("led_o", 32'(led_m), 32'(led_i));
        data_errs++;
      end
      if (dac_rst_i !== reset_i) begin
        report_value("dac_rst_o", 32'(reset_i), 32'(dac_rst_i));
        data_errs++;
      end

      region = int'(addr_i[REGION_LSB +: REGION_W]);
      in_ch  = (region >= CH_BASE_REGION) && (region < CH_BASE_REGION + N_CH);
      if (ack_due) begin  // edge after a channel strobe
        ack_due = 1'b0;
        if (ack_i !== 1'b1) begin
          $display("%s: no acknowledge from channel region at address %h", test_name, addr_i);
          bus_errs++;
        end else if (rd_due && rdata_i !== rd_exp) begin
          report_value("sys_rdata_o", rd_exp, rdata_i);
          bus_errs++;
        end
      end else if (wen_i || ren_i) begin
        if (in_ch) begin
          if (ack_i !== 1'b0) begin
            $display("%s: channel region acknowledged in the strobe cycle", test_name);
            bus_errs++;
          end
          ack_due = 1'b1;
          rd_due  = ren_i;
          rd_exp  = read_value(region, int'(addr_i[REG_LSB +: REG_W]));
        end else if (ack_i !== 1'b1) begin
          $display("%s: empty region %0d gave no acknowledge with the strobe", test_name, region);
          bus_errs++;
        end else if (ren_i && rdata_i !== '0) begin
          report_value("sys_rdata_o", '0, rdata_i);
          bus_errs++;
        end
      end else if (ack_i !== 1'b0) begin
        $display("%s: acknowledge seen with no access pending", test_name);
        bus_errs++;
      end
    end
  end

endmodule

// File: verilog/pitaya_top.sv
/*
 * Board top, adc_clk slice. ADC front end, a row of gain and offset
 * channels on the system bus, and the DAC output stage.
 */
`timescale 1ns/1ps

module pitaya_top #(
  parameter int N_CH = 2  // 1 to 7 channels
) (
  input  logic                  adc_clk,
  input  logic                  reset_i,      // sync, active high
  input  analog_pkg::dac_code_t adc_dat_a_i,  // ADC channel a
  input  analog_pkg::dac_code_t adc_dat_b_i,  // ADC channel b
  input  bus_pkg::sys_addr_t    sys_addr_i,
  input  bus_pkg::sys_data_t    sys_wdata_i,
  input  logic                  sys_wen_i,
  input  logic                  sys_ren_i,
  output bus_pkg::sys_data_t    sys_rdata_o,
  output logic                  sys_ack_o,
  output analog_pkg::dac_code_t dac_dat_a_o,
  output analog_pkg::dac_code_t dac_dat_b_o,
  output logic                  dac_rst_o,
  output logic [N_CH-1:0]       led_o         // saturation per channel
);

  import bus_pkg::*;
  import analog_pkg::*;

  localparam int N_ADC = 2;  // converter inputs on the board

  sample_t   [N_ADC-1:0] adc_sample;
  logic      [N_CH-1:0]  ch_wen;
  logic      [N_CH-1:0]  ch_ren;
  sys_data_t [N_CH-1:0]  ch_rdata;
  logic      [N_CH-1:0]  ch_ack;
  sample_t   [N_CH-1:0]  ch_result;
  logic      [N_CH-1:0]  ch_sat;

  // ----------------------------------------
  // front end
  adc_frontend u_adc_frontend (
    .adc_clk      (adc_clk),
    .reset_i      (reset_i),
    .adc_dat_a_i  (adc_dat_a_i),
    .adc_dat_b_i  (adc_dat_b_i),
    .adc_sample_o (adc_sample)
  );

  // ----------------------------------------
  // bus decoder
  sys_bus_decoder #(.N_CH(N_CH)) u_sys_bus_decoder (
    .sys_addr_i  (sys_addr_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .ch_rdata_i  (ch_rdata),
    .ch_ack_i    (ch_ack),
    .ch_wen_o    (ch_wen),
    .ch_ren_o    (ch_ren),
    .sys_rdata_o (sys_rdata_o),
    .sys_ack_o   (sys_ack_o)
  );

  // ----------------------------------------
  // channels, region 1+i each
  for (genvar i = 0; i < N_CH; i++) begin : g_ch
    dac_channel u_dac_channel (
      .adc_clk     (adc_clk),
      .reset_i     (reset_i),
      .sample_i    (adc_sample[i % N_ADC]),  // extra channels reuse the inputs
      .sys_addr_i  (sys_addr_i),
      .sys_wdata_i (sys_wdata_i),
      .sys_wen_i   (ch_wen[i]),
      .sys_ren_i   (ch_ren[i]),
      .sys_rdata_o (ch_rdata[i]),
      .sys_ack_o   (ch_ack[i]),
      .result_o    (ch_result[i]),
      .sat_o       (ch_sat[i])
    );
  end

  // ----------------------------------------
  // output stage
  dac_output #(.N_CH(N_CH)) u_dac_output (
    .adc_clk     (adc_clk),
    .reset_i     (reset_i),
    .result_i    (ch_result),
    .sat_i       (ch_sat),
    .dac_dat_a_o (dac_dat_a_o),
    .dac_dat_b_o (dac_dat_b_o),
    .dac_rst_o   (dac_rst_o),
    .led_o       (led_o)
  );

endmodule

// File: verilog/dac_output.sv
/*
 * DAC output stage. Registers channel results in converter code,
 * shows saturation on the LEDs and drives the converter reset.
 */
`timescale 1ns/1ps

module dac_output #(
  parameter int N_CH = 2
) (
  input  logic                             adc_clk,
  input  logic                             reset_i,      // sync, active high
  input  analog_pkg::sample_t [N_CH-1:0]   result_i,     // per channel result
  input  logic                [N_CH-1:0]   sat_i,        // per channel clamp flag
  output analog_pkg::dac_code_t            dac_dat_a_o,  // channel 0
  output analog_pkg::dac_code_t            dac_dat_b_o,  // last channel
  output logic                             dac_rst_o,
  output logic                [N_CH-1:0]   led_o         // lit while clamping
);

  import analog_pkg::*;

  // code for a zero sample, mid scale
  localparam dac_code_t DAC_ZERO = {1'b0, {(SAMPLE_W - 1){1'b1}}};

  // ----------------------------------------
  // output register, cycle 4
  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      dac_dat_a_o <= DAC_ZERO;
      dac_dat_b_o <= DAC_ZERO;
      led_o       <= '0;
    end else begin
      dac_dat_a_o <= dac_code_t'(flip_code(result_i[0]));         // back to converter code
      dac_dat_b_o <= dac_code_t'(flip_code(result_i[N_CH - 1]));  // with one channel, same as a
      led_o       <= sat_i;  // lines up with the codes
    end
  end

  // converter held in reset with the system
  assign dac_rst_o = reset_i;

endmodule

// File: verilog/dac_channel.sv
/*
 * One output channel. Holds gain and offset on the system bus and runs
 * the scale, add and saturate pipeline on the incoming sample.
 */
`timescale 1ns/1ps

module dac_channel (
  input  logic                adc_clk,
  input  logic                reset_i,      // sync, active high
  input  analog_pkg::sample_t sample_i,     // from the front end
  input  bus_pkg::sys_addr_t  sys_addr_i,
  input  bus_pkg::sys_data_t  sys_wdata_i,
  input  logic                sys_wen_i,    // already gated by region
  input  logic                sys_ren_i,
  output bus_pkg::sys_data_t  sys_rdata_o,
  output logic                sys_ack_o,    // one edge after strobe
  output analog_pkg::sample_t result_o,     // saturated result
  output logic                sat_o         // clamp applied to result_o
);

  import bus_pkg::*;
  import analog_pkg::*;

  logic [REG_W-1:0] reg_sel;    // slot from addr[3:2]
  sample_t          offset_q;   // added after scaling
  gain_t            gain_q;     // KP_FRAC fraction bits
  product_t         prod_q;     // stage 2
  sum_t             sum;        // scaled product plus offset
  sample_t          clamped;
  logic             clamp_hit;

  assign reg_sel = sys_addr_i[REG_LSB +: REG_W];

  // ----------------------------------------
  // register slots
  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      offset_q    <= '0;
      gain_q      <= '0;
      sys_ack_o   <= 1'b0;
      sys_rdata_o <= '0;
    end else begin
      sys_ack_o <= sys_wen_i | sys_ren_i;  // every access acks next edge

      if (sys_wen_i) begin
        case (reg_sel)
          REG_OFFSET: offset_q <= sample_t'(sys_wdata_i[SAMPLE_W-1:0]);
          REG_GAIN:   gain_q   <= gain_t'(sys_wdata_i[GAIN_W-1:0]);
          default:    ;  // slots 2 and 3 ignore writes
        endcase
      end

      if (sys_ren_i) begin
        case (reg_sel)
          REG_OFFSET: sys_rdata_o <= {{(SYS_DW - SAMPLE_W){offset_q[SAMPLE_W-1]}}, offset_q};
          REG_GAIN:   sys_rdata_o <= {{(SYS_DW - GAIN_W){gain_q[GAIN_W-1]}}, gain_q};
          default:    sys_rdata_o <= '0;  // unused slots
        endcase
      end
    end
  end

  // ----------------------------------------
  // shift, add and clamp
  always_comb begin
    // dropping the KP_FRAC low bits is the arithmetic right shift
    sum = sum_t'($signed(prod_q[PRODUCT_W-1:KP_FRAC])) + sum_t'(offset_q);

    if (sum > sum_t'(SAT_MAX)) begin
      clamped   = sample_t'(SAT_MAX);  // positive overflow
      clamp_hit = 1'b1;
    end else if (sum < sum_t'(SAT_MIN)) begin
      clamped   = sample_t'(SAT_MIN);  // negative overflow
      clamp_hit = 1'b1;
    end else begin
      clamped   = sum[SAMPLE_W-1:0];   // in range so plain truncation
      clamp_hit = 1'b0;
    end
  end

  // ----------------------------------------
  // product and result pipeline
  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      prod_q   <= '0;
      result_o <= '0;
      sat_o    <= 1'b0;
    end else begin
      prod_q   <= product_t'(sample_i) * product_t'(gain_q);  // signed 14x16 in cycle 2
      result_o <= clamped;            // cycle 3
      sat_o    <= clamp_hit;          // same sample as result_o
    end
  end

endmodule

// File: verilog/adc_frontend.sv
/*
 * ADC front end. Registers both converter words and turns the
 * negative slope offset code into two's complement samples.
 */
`timescale 1ns/1ps

module adc_frontend (
  input  logic                      adc_clk,
  input  logic                      reset_i,       // sync, active high
  input  analog_pkg::dac_code_t     adc_dat_a_i,   // raw code, channel a
  input  analog_pkg::dac_code_t     adc_dat_b_i,   // raw code, channel b
  output analog_pkg::sample_t [1:0] adc_sample_o   // [0] is a, [1] is b
);

  import analog_pkg::*;

  // ----------------------------------------
  // input register, one cycle
  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      adc_sample_o <= '0;  // zero sample during reset
    end else begin
      adc_sample_o[0] <= sample_t'(flip_code(adc_dat_a_i));  // keep msb, invert rest
      adc_sample_o[1] <= sample_t'(flip_code(adc_dat_b_i));
    end
  end

endmodule

// File: verilog/sys_bus_decoder.sv
/*
 * System bus decoder. Splits the address map into eight regions,
 * steers the strobes to the channels and muxes read data and ack back.
 */
`timescale 1ns/1ps

module sys_bus_decoder #(
  parameter int N_CH = 2  // channels behind regions 1..N_CH
) (
  input  bus_pkg::sys_addr_t            sys_addr_i,  // held until ack
  input  logic                          sys_wen_i,   // one cycle write strobe
  input  logic                          sys_ren_i,   // one cycle read strobe
  input  bus_pkg::sys_data_t [N_CH-1:0] ch_rdata_i,  // per channel read data
  input  logic               [N_CH-1:0] ch_ack_i,    // per channel ack
  output logic               [N_CH-1:0] ch_wen_o,
  output logic               [N_CH-1:0] ch_ren_o,
  output bus_pkg::sys_data_t            sys_rdata_o,
  output logic                          sys_ack_o
);

  import bus_pkg::*;

  logic [REGION_W-1:0] region;      // addr[22:20]
  region_sel_t         region_sel;  // one-hot of region

  assign region = sys_addr_i[REGION_LSB +: REGION_W];

  always_comb begin
    region_sel         = '0;
    region_sel[region] = 1'b1;
  end

  // ----------------------------------------
  // strobes into the channel regions
  always_comb begin
    for (int i = 0; i < N_CH; i++) begin
      ch_wen_o[i] = region_sel[CH_BASE_REGION + i] & sys_wen_i;  // gated by select
      ch_ren_o[i] = region_sel[CH_BASE_REGION + i] & sys_ren_i;
    end
  end

  // ----------------------------------------
  // read data and ack back to the master
  always_comb begin
    sys_rdata_o = '0;                     // empty region reads zero
    sys_ack_o   = sys_wen_i | sys_ren_i;  // and acks with the strobe
    for (int i = 0; i < N_CH; i++) begin
      if (region_sel[CH_BASE_REGION + i]) begin
        sys_rdata_o = ch_rdata_i[i];  // registered in the channel
        sys_ack_o   = ch_ack_i[i];    // one edge after the strobe
      end
    end
  end

endmodule

// File: verilog/analog_pkg.sv
/*
 * Analog path definitions. Sample, gain, product and sum types, the
 * 14 bit saturation limits and the converter code flip.
 */
package analog_pkg;

  // ----------------------------------------
  // widths
  localparam int SAMPLE_W  = 14;                        // converter width
  localparam int GAIN_W    = 16;
  localparam int KP_FRAC   = 8;                         // 256 is unity gain
  localparam int PRODUCT_W = SAMPLE_W + GAIN_W;         // 30 bit full product
  localparam int SUM_W     = PRODUCT_W - KP_FRAC + 1;   // scaled product plus offset

  // ----------------------------------------
  // types
  typedef logic signed [SAMPLE_W-1:0]  sample_t;    // two's complement sample
  typedef logic        [SAMPLE_W-1:0]  dac_code_t;  // raw converter code
  typedef logic signed [GAIN_W-1:0]    gain_t;
  typedef logic signed [PRODUCT_W-1:0] product_t;
  typedef logic signed [SUM_W-1:0]     sum_t;

  // saturation limits of a 14 bit sample
  localparam int SAT_MAX = (1 << (SAMPLE_W - 1)) - 1;  // +8191
  localparam int SAT_MIN = -(1 << (SAMPLE_W - 1));     // -8192

  // converter code <-> two's complement, same rule both ways
  // msb kept, the rest inverted (negative slope code)
  function automatic logic [SAMPLE_W-1:0] flip_code(input logic [SAMPLE_W-1:0] v);
    return {v[SAMPLE_W-1], ~v[SAMPLE_W-2:0]};
  endfunction

endpackage

// File: verilog/bus_pkg.sv
/*
 * System bus definitions. Address and data widths, the region field
 * that splits the address map, and the register slots of a channel.
 */
package bus_pkg;

  // ----------------------------------------
  // bus widths
  localparam int SYS_AW = 32;  // byte address
  localparam int SYS_DW = 32;  // data word

  // ----------------------------------------
  // region decoding
  localparam int N_REGIONS      = 8;
  localparam int REGION_W       = $clog2(N_REGIONS);  // 3 bit field
  localparam int REGION_LSB     = 20;                 // field sits in addr[22:20]
  localparam int CH_BASE_REGION = 1;                  // channel i lives in region 1+i

  // register slot inside a channel region
  localparam int REG_LSB = 2;  // word aligned slots
  localparam int REG_W   = 2;  // four slots, two in use

  localparam logic [REG_W-1:0] REG_OFFSET = 2'd0;  // output level
  localparam logic [REG_W-1:0] REG_GAIN   = 2'd1;  // proportional gain

  // ----------------------------------------
  // bus types
  typedef logic [SYS_AW-1:0]    sys_addr_t;
  typedef logic [SYS_DW-1:0]    sys_data_t;
  typedef logic [N_REGIONS-1:0] region_sel_t;  // one-hot

endpackage
